//--- Makefile
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f particle_pusher.f \
		--top-module tb_particle_pusher -Mdir $(BUILD_DIR) -o tb_particle_pusher
	./$(BUILD_DIR)/tb_particle_pusher | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- particle_pusher.f
src/pusher_pkg.sv
src/pipe_delay.sv
src/gyro_stencil.sv
src/bilinear_coeff.sv
src/efield_stencil.sv
src/field_interp.sv
src/exb_update.sv
src/particle_pusher.sv
verif/particle_pusher_sva.sv
verif/tb_particle_pusher.sv

//--- src/bilinear_coeff.sv
module bilinear_coeff (
    input  logic                                             clk,
    input  logic                                             rst_ff,
    input  logic                                             valid_frac,
    input  pusher_pkg::frac_pair_t [pusher_pkg::NUM_GYRO-1:0] frac,
    output logic                                             valid_coeff,
    output pusher_pkg::coeff_set_t                           coeff
);
    import pusher_pkg::*;

    typedef logic [FRAC_BITS:0] wfrac_t;    // one extra bit for full scale

    // 1 - f, so a zero fraction gives exactly 1.0 (2**FRAC_BITS)
    function automatic wfrac_t complement(input logic [FRAC_BITS-1:0] f);
        return wfrac_t'(1 << FRAC_BITS) - wfrac_t'(f);
    endfunction

    function automatic coeff_t weight(input wfrac_t wy, input wfrac_t wx);
        return wy * wx;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_ff) begin
            valid_coeff <= 1'b0;
        end else begin
            valid_coeff <= valid_frac;
        end
    end

    // four weights sum to 2**(2*FRAC_BITS) for every gyropoint
    always_ff @(posedge clk) begin
        for (int g = 0; g < NUM_GYRO; g++) begin
            coeff[g][0] <= weight(complement(frac[g].y), complement(frac[g].x)); // LL
            coeff[g][1] <= weight(complement(frac[g].y), wfrac_t'(frac[g].x));   // LR
            coeff[g][2] <= weight(wfrac_t'(frac[g].y), complement(frac[g].x));   // UL
            coeff[g][3] <= weight(wfrac_t'(frac[g].y), wfrac_t'(frac[g].x));     // UR
        end
    end

endmodule

//--- src/efield_stencil.sv
module efield_stencil (
    input  logic                          clk,
    input  logic                          rst_ff,
    input  logic                          valid_phi,
    input  pusher_pkg::phi_stencil_t      phi_in,
    output logic                          valid_field,
    output pusher_pkg::corner_field_t     field
);
    import pusher_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // stencil entries on either side of each corner (LL, LR, UL, UR)
    ////////////////////////////////////////////////////////////////////////////

    localparam int EY_HI [NUM_CORNERS] = '{2, 3, 10, 11};
    localparam int EY_LO [NUM_CORNERS] = '{8, 9, 0, 1};
    localparam int EX_HI [NUM_CORNERS] = '{1, 5, 3, 7};
    localparam int EX_LO [NUM_CORNERS] = '{4, 0, 6, 2};

    corner_field_t diff;

    // central difference over two cells
    function automatic ef_t half_diff(input phi_t hi, input phi_t lo);
        ef_t d;
        d = hi - lo;    // sign-extended into the extra bit
        return d >>> 1;
    endfunction

    // differences taken straight off the memory port
    always_comb begin
        for (int g = 0; g < NUM_GYRO; g++) begin
            for (int c = 0; c < NUM_CORNERS; c++) begin
                diff[g][c].y = half_diff(phi_in[g][EY_HI[c]], phi_in[g][EY_LO[c]]);
                diff[g][c].x = half_diff(phi_in[g][EX_HI[c]], phi_in[g][EX_LO[c]]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_ff) begin
            valid_field <= 1'b0;
        end else begin
            valid_field <= valid_phi;
        end
    end

    always_ff @(posedge clk) begin
        field <= diff;    // capture on the phi return cycle
    end

endmodule

//--- src/exb_update.sv
module exb_update (
    input  logic                                  clk,
    input  logic                                  rst_ff,
    input  logic                                  valid_avg,
    input  logic signed [pusher_pkg::EF_BITS-1:0] ef_y,
    input  logic signed [pusher_pkg::EF_BITS-1:0] ef_x,
    input  pusher_pkg::particle_t                 particle,
    input  logic                                  noop,
    output logic                                  valid_out,
    output pusher_pkg::particle_t                 particle_out
);
    import pusher_pkg::*;

    logic signed [EF_BITS-1:0] disp_y;
    logic signed [EF_BITS-1:0] disp_x;
    logic                      valid_upd;
    particle_t                 upd;

    // cross product with uniform B swaps the axes and negates the new x
    assign disp_y = ef_x >>> EXB_SHIFT;
    assign disp_x = (-ef_y) >>> EXB_SHIFT;

    always_ff @(posedge clk) begin
        if (rst_ff) begin
            valid_upd <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            valid_upd <= valid_avg;
            valid_out <= valid_upd;
        end
    end

    always_ff @(posedge clk) begin
        upd.r <= particle.r;
        if (noop) begin
            upd.y <= particle.y;
            upd.x <= particle.x;
        end else begin
            upd.y <= pos_t'(particle.y + POS_BITS'(disp_y));    // overflow is the periodic wrap
            upd.x <= pos_t'(particle.x + POS_BITS'(disp_x));
        end
        particle_out <= upd;
    end

endmodule

//--- src/field_interp.sv
module field_interp (
    input  logic                                     clk,
    input  logic                                     rst_ff,
    input  logic                                     valid_field,
    input  pusher_pkg::corner_field_t                field,
    input  pusher_pkg::coeff_set_t                   coeff,
    output logic                                     valid_avg,
    output logic signed [pusher_pkg::EF_BITS-1:0]    ef_y,
    output logic signed [pusher_pkg::EF_BITS-1:0]    ef_x
);
    import pusher_pkg::*;

    localparam int NUM_TERMS   = NUM_GYRO * NUM_CORNERS;
    localparam int TREE_LEVELS = $clog2(NUM_TERMS);
    localparam int SUM_BITS    = EF_BITS + COEFF_BITS + 1 + TREE_LEVELS;
    // weight scale plus the divide by NUM_GYRO
    localparam int AVG_SHIFT   = 2 * FRAC_BITS + $clog2(NUM_GYRO);

    logic [TREE_LEVELS+1:0]     valid_pipe;    // multiply, tree, average
    logic signed [SUM_BITS-1:0] tree_y [TREE_LEVELS+1][NUM_TERMS];
    logic signed [SUM_BITS-1:0] tree_x [TREE_LEVELS+1][NUM_TERMS];

    always_ff @(posedge clk) begin
        if (rst_ff) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[TREE_LEVELS:0], valid_field};
        end
    end

    always_ff @(posedge clk) begin
        // level 0 holds the weighted corner fields
        for (int g = 0; g < NUM_GYRO; g++) begin
            for (int c = 0; c < NUM_CORNERS; c++) begin
                tree_y[0][g*NUM_CORNERS+c] <= $signed(field[g][c].y)
                                              * $signed({1'b0, coeff[g][c]});
                tree_x[0][g*NUM_CORNERS+c] <= $signed(field[g][c].x)
                                              * $signed({1'b0, coeff[g][c]});
            end
        end
        for (int l = 1; l <= TREE_LEVELS; l++) begin
            for (int i = 0; i < (NUM_TERMS >> l); i++) begin
                tree_y[l][i] <= tree_y[l-1][2*i] + tree_y[l-1][2*i+1];
                tree_x[l][i] <= tree_x[l-1][2*i] + tree_x[l-1][2*i+1];
            end
        end
        ef_y <= EF_BITS'(tree_y[TREE_LEVELS][0] >>> AVG_SHIFT);
        ef_x <= EF_BITS'(tree_x[TREE_LEVELS][0] >>> AVG_SHIFT);
    end

    assign valid_avg = valid_pipe[TREE_LEVELS+1];

endmodule

//--- src/gyro_stencil.sv
module gyro_stencil (
    input  logic                                              clk,
    input  logic                                              rst_ff,
    input  logic                                              valid,
    input  pusher_pkg::particle_t                             particle_in,
    output logic                                              valid_req,
    output pusher_pkg::addr_stencil_t                         raddr,
    output logic                                              valid_frac,
    output pusher_pkg::frac_pair_t [pusher_pkg::NUM_GYRO-1:0] frac
);
    import pusher_pkg::*;

    // node offsets (dy, dx) from the lower-left corner, in stencil order
    localparam int OFF_Y [NUM_STENCIL] = '{0, 0, 1, 1,  0, 0,  1, 1, -1, -1, 2, 2};
    localparam int OFF_X [NUM_STENCIL] = '{0, 1, 0, 1, -1, 2, -1, 2,  0,  1, 0, 1};

    logic                valid_gp;
    logic                valid_addr;
    pos_t [NUM_GYRO-1:0] gp_y;
    pos_t [NUM_GYRO-1:0] gp_x;

    function automatic grid_addr_t node(input pos_t py, input pos_t px,
                                        input int dy, input int dx);
        grid_addr_t a;
        a.y = py.whole + GRID_BITS'(dy);    // wraps mod grid size
        a.x = px.whole + GRID_BITS'(dx);
        return a;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_ff) begin
            valid_gp   <= 1'b0;
            valid_addr <= 1'b0;
        end else begin
            valid_gp   <= valid;
            valid_addr <= valid_gp;
        end
    end

    // four points on the gyro-circle at x-r, x+r, y-r and y+r
    always_ff @(posedge clk) begin
        gp_y[0] <= particle_in.y;
        gp_x[0] <= pos_t'(particle_in.x - particle_in.r);
        gp_y[1] <= particle_in.y;
        gp_x[1] <= pos_t'(particle_in.x + particle_in.r);
        gp_y[2] <= pos_t'(particle_in.y - particle_in.r);
        gp_x[2] <= particle_in.x;
        gp_y[3] <= pos_t'(particle_in.y + particle_in.r);
        gp_x[3] <= particle_in.x;
    end

    always_ff @(posedge clk) begin
        for (int g = 0; g < NUM_GYRO; g++) begin
            for (int s = 0; s < NUM_STENCIL; s++) begin
                raddr[g][s] <= node(gp_y[g], gp_x[g], OFF_Y[s], OFF_X[s]);
            end
            frac[g].y <= gp_y[g].fraction;
            frac[g].x <= gp_x[g].fraction;
        end
    end

    assign valid_req  = valid_addr;
    assign valid_frac = valid_addr;    // fractions leave with the addresses

endmodule

//--- src/particle_pusher.sv
module particle_pusher (
    input  logic                      clk,
    input  logic                      rst_ff,
    input  logic                      valid,
    input  logic                      noop,
    input  pusher_pkg::particle_t     particle_in,
    input  pusher_pkg::phi_stencil_t  phi_in,
    output logic                      valid_out,
    output pusher_pkg::particle_t     particle_out,
    output logic                      valid_req,
    output pusher_pkg::addr_stencil_t raddr
);
    import pusher_pkg::*;

    typedef struct packed {
        logic      noop;
        particle_t particle;
    } push_job_t;

    logic                      valid_frac;
    frac_pair_t [NUM_GYRO-1:0] frac;
    coeff_set_t                coeff;
    coeff_set_t                coeff_d;
    logic                      valid_phi;
    logic                      valid_field;
    corner_field_t             field;
    logic                      valid_avg;
    logic signed [EF_BITS-1:0] ef_y;
    logic signed [EF_BITS-1:0] ef_x;
    push_job_t                 job;
    push_job_t                 job_d;

    assign job = '{noop: noop, particle: particle_in};

    gyro_stencil u_gyro (.clk, .rst_ff, .valid, .particle_in, .valid_req, .raddr,
                         .valid_frac, .frac);

    bilinear_coeff u_coeff (.clk, .rst_ff, .valid_frac, .frac, .valid_coeff(), .coeff);

    // valid chain starts at valid_req and marks the phi return cycle,
    // weights enter a cycle later and leave with the differenced field
    pipe_delay #(.T(coeff_set_t), .DEPTH(PHI_LATENCY)) coeff_delay (
        .clk, .rst_ff, .valid(valid_req), .data(coeff),
        .valid_out(valid_phi), .data_out(coeff_d));

    efield_stencil u_efield (.clk, .rst_ff, .valid_phi, .phi_in, .valid_field, .field);

    field_interp u_interp (.clk, .rst_ff, .valid_field, .field, .coeff(coeff_d),
                           .valid_avg, .ef_y, .ef_x);

    // particle meets its averaged field two cycles before the output
    pipe_delay #(.T(push_job_t), .DEPTH(PUSH_LATENCY - 2)) particle_delay (
        .clk, .rst_ff, .valid, .data(job), .valid_out(), .data_out(job_d));

    exb_update u_exb (.clk, .rst_ff, .valid_avg, .ef_y, .ef_x,
                      .particle(job_d.particle), .noop(job_d.noop),
                      .valid_out, .particle_out);

endmodule

//--- src/pipe_delay.sv
module pipe_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic rst_ff,
    input  logic valid,
    input  T     data,
    output logic valid_out,
    output T     data_out
);

    logic [DEPTH-1:0] valid_sr;
    T                 data_sr [DEPTH];

    always_ff @(posedge clk) begin
        if (rst_ff) begin
            valid_sr <= '0;
        end else begin
            valid_sr[0] <= valid;
            for (int i = 1; i < DEPTH; i++) begin
                valid_sr[i] <= valid_sr[i-1];
            end
        end
    end

    // payload shifts every cycle, alignment comes from the fixed depth
    always_ff @(posedge clk) begin
        data_sr[0] <= data;
        for (int i = 1; i < DEPTH; i++) begin
            data_sr[i] <= data_sr[i-1];
        end
    end

    assign valid_out = valid_sr[DEPTH-1];
    assign data_out  = data_sr[DEPTH-1];

endmodule

//--- src/pusher_pkg.sv
package pusher_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and pipeline constants
    ////////////////////////////////////////////////////////////////////////////

    localparam int GRID_BITS  = 8;                     // 256 x 256 periodic grid
    localparam int FRAC_BITS  = 12;
    localparam int POS_BITS   = GRID_BITS + FRAC_BITS;
    localparam int PHI_BITS   = 16;                    // signed potential sample
    localparam int EF_BITS    = PHI_BITS + 1;
    localparam int COEFF_BITS = 2 * FRAC_BITS + 1;     // full weight is 2**24

    localparam int NUM_GYRO    = 4;
    localparam int NUM_STENCIL = 12;
    localparam int NUM_CORNERS = 4;                    // LL, LR, UL, UR

    localparam int PHI_LATENCY  = 2;                   // external phi memory
    localparam int EXB_SHIFT    = 3;                   // stands in for 1/B
    localparam int PUSH_LATENCY = 13;

    ////////////////////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////////////////////

    // y index in the upper byte
    typedef struct packed {
        logic [GRID_BITS-1:0] y;
        logic [GRID_BITS-1:0] x;
    } grid_addr_t;

    typedef struct packed {
        logic [GRID_BITS-1:0] whole;
        logic [FRAC_BITS-1:0] fraction;
    } pos_t;

    typedef struct packed {
        pos_t y;
        pos_t x;
        pos_t r;    // gyroradius, carried by the particle
    } particle_t;

    typedef struct packed {
        logic [FRAC_BITS-1:0] y;
        logic [FRAC_BITS-1:0] x;
    } frac_pair_t;

    typedef logic signed [PHI_BITS-1:0] phi_t;
    typedef logic signed [EF_BITS-1:0]  ef_t;
    typedef logic [COEFF_BITS-1:0]      coeff_t;

    typedef struct packed {
        ef_t y;
        ef_t x;
    } ef_pair_t;

    // each gyropoint holds corners LL LR UL UR at 0-3,
    // row neighbours x-1 and x+2 at 4-7 and column neighbours y-1 and y+2 at 8-11
    typedef phi_t       [NUM_GYRO-1:0][NUM_STENCIL-1:0] phi_stencil_t;
    typedef grid_addr_t [NUM_GYRO-1:0][NUM_STENCIL-1:0] addr_stencil_t;
    typedef coeff_t     [NUM_GYRO-1:0][NUM_CORNERS-1:0] coeff_set_t;
    typedef ef_pair_t   [NUM_GYRO-1:0][NUM_CORNERS-1:0] corner_field_t;

endpackage

//--- verif/particle_pusher_sva.sv
module particle_pusher_sva (
    input logic                  clk,
    input logic                  rst_ff,
    input logic                  valid,
    input logic                  valid_req,
    input logic                  valid_out,
    input pusher_pkg::particle_t particle_out
);
    timeunit 1ns;
    timeprecision 1ps;
    import pusher_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // fixed pipeline timing
    ////////////////////////////////////////////////////////////////////////////

    a_req_after_valid: assert property (@(posedge clk) disable iff (rst_ff)
        $past(valid, 2) |-> valid_req)
        else $error("valid_req missing two cycles after valid");

    a_req_has_valid: assert property (@(posedge clk) disable iff (rst_ff)
        valid_req |-> $past(valid, 2))
        else $error("valid_req without valid two cycles before");

    a_out_after_valid: assert property (@(posedge clk) disable iff (rst_ff)
        $past(valid, PUSH_LATENCY) |-> valid_out)
        else $error("valid_out missing at the push latency");

    a_out_has_valid: assert property (@(posedge clk) disable iff (rst_ff)
        valid_out |-> $past(valid, PUSH_LATENCY))
        else $error("valid_out without a matching valid");

    // strobes quiet through reset and one cycle past it
    a_quiet_reset: assert property (@(posedge clk)
        $past(rst_ff) |-> !valid_req && !valid_out)
        else $error("strobe high during or right after reset");

    a_out_known: assert property (@(posedge clk) disable iff (rst_ff)
        valid_out |-> !$isunknown(particle_out))
        else $error("particle_out has unknown bits");

endmodule

bind particle_pusher particle_pusher_sva u_sva (
    .clk(clk),
    .rst_ff(rst_ff),
    .valid(valid),
    .valid_req(valid_req),
    .valid_out(valid_out),
    .particle_out(particle_out)
);

//--- verif/tb_particle_pusher.sv
module tb_particle_pusher;
    timeunit 1ns;
    timeprecision 1ps;
    import pusher_pkg::*;

    localparam int WAIT_LIMIT  = PUSH_LATENCY + 40;
    localparam int FIELD_A [4] = '{-60, 45, -1, 7};
    localparam int FIELD_B [4] = '{37, -52, -9, 0};

    logic          clk = 1'b0;
    logic          rst_ff;
    logic          valid;
    logic          noop;
    particle_t     particle_in;
    phi_stencil_t  phi_in;
    logic          valid_out;
    particle_t     particle_out;
    logic          valid_req;
    addr_stencil_t raddr;

    logic [15:0]   lfsr = 16'd5412;
    int            phi_a;            // phi = a*x + b*y
    int            phi_b;
    particle_t     exp_q [$];
    string         name_q [$];
    particle_t     req_q [$];        // inputs awaiting their valid_req

    particle_pusher UUT (.*);

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    // galois lfsr stepped once per bit taken
    function automatic int lfsr_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic pos_t random_pos(input int lo, input int span);
        pos_t p;
        p.whole    = GRID_BITS'(lo + lfsr_bits(8) % span);
        p.fraction = FRAC_BITS'(lfsr_bits(FRAC_BITS));
        return p;
    endfunction

    // stencils stay clear of the grid edge
    function automatic particle_t make_particle();
        particle_t p;
        p.y = random_pos(16, 224);
        p.x = random_pos(16, 224);
        p.r = random_pos(0, 4);       // below 4 cells
        return p;
    endfunction

    function automatic pos_t shifted(input pos_t p, input int delta);
        logic [POS_BITS-1:0] sum;
        sum = POS_BITS'(int'(p) + delta);    // periodic wrap
        return sum;
    endfunction

    task automatic send(input particle_t p, input logic hold, input string name);
        particle_t e;
        e = p;
        if (!hold) begin
            e.y = shifted(p.y, phi_a >>> EXB_SHIFT);
            e.x = shifted(p.x, (-phi_b) >>> EXB_SHIFT);
        end
        exp_q.push_back(e);
        name_q.push_back(name);
        req_q.push_back(p);
        valid       = 1'b1;
        noop        = hold;
        particle_in = p;
        @(posedge clk);
        #1;
        valid = 1'b0;
    endtask

    task automatic wait_drain(input string name);
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (exp_q.size() != 0) begin
            fail_run($sformatf("%s timed out with %0d particles not returned", name,
                               exp_q.size()));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // phi memory and monitors
    ////////////////////////////////////////////////////////////////////////////

    initial begin : phi_memory
        logic          pend_valid [$];
        addr_stencil_t pend_addr [$];
        logic          v;
        addr_stencil_t a;
        phi_in = '0;
        for (int i = 0; i < PHI_LATENCY - 1; i++) begin
            pend_valid.push_back(1'b0);
            pend_addr.push_back('0);
        end
        forever begin
            @(posedge clk);
            pend_valid.push_back(valid_req);
            pend_addr.push_back(raddr);
            #1;
            v = pend_valid.pop_front();
            a = pend_addr.pop_front();
            if (v) begin
                for (int g = 0; g < NUM_GYRO; g++) begin
                    for (int s = 0; s < NUM_STENCIL; s++) begin
                        phi_in[g][s] = PHI_BITS'(phi_a * int'(a[g][s].x)
                                                 + phi_b * int'(a[g][s].y));
                    end
                end
            end
        end
    end

    always @(posedge clk) begin : scoreboard
        particle_t exp;
        string     name;
        if (!rst_ff && valid_out) begin
            if (exp_q.size() == 0) begin
                fail_run("valid_out came with no particle in flight");
            end else begin
                exp  = exp_q.pop_front();
                name = name_q.pop_front();
                assert (particle_out == exp) else
                    fail_run($sformatf("FAILED %s expected %h actual %h", name, exp,
                                       particle_out));
            end
        end
    end

    // gyropoint 0 lower-left corner sits at (y, x - r)
    always @(posedge clk) begin : addr_check
        particle_t  p;
        grid_addr_t exp;
        if (!rst_ff && valid_req) begin
            if (req_q.size() == 0) begin
                fail_run("valid_req came with no particle sent");
            end else begin
                p     = req_q.pop_front();
                exp.y = p.y.whole;
                exp.x = GRID_BITS'((int'(p.x) - int'(p.r)) >>> FRAC_BITS);
                assert (raddr[0][0] == exp) else
                    fail_run($sformatf("FAILED addresses expected %h actual %h", exp,
                                       raddr[0][0]));
            end
        end
    end

    initial begin : main
        particle_t p;
        rst_ff      = 1'b1;
        valid       = 1'b0;
        noop        = 1'b0;
        particle_in = '0;
        phi_a       = 0;
        phi_b       = 0;
        repeat (10) @(posedge clk);
        #1;
        rst_ff = 1'b0;

        // fixed fields with both signs, then random ones
        for (int t = 0; t < 6; t++) begin
            phi_a = (t < 4) ? FIELD_A[t] : lfsr_bits(7) % 121 - 60;
            phi_b = (t < 4) ? FIELD_B[t] : lfsr_bits(7) % 121 - 60;
            for (int i = 0; i < 3; i++) begin
                send(make_particle(), 1'b0, "drift");
                wait_drain("drift");
            end
        end

        // a field that moves both axes, so held and pushed particles differ
        phi_a = FIELD_A[1];
        phi_b = FIELD_B[1];

        send(make_particle(), 1'b1, "noop");
        send(make_particle(), 1'b0, "noop");
        send(make_particle(), 1'b1, "noop");
        wait_drain("noop");

        // zero fractions hit the full-scale complement
        p = make_particle();
        p.y.fraction = '0;
        p.x.fraction = '0;
        p.r.fraction = '0;
        send(p, 1'b0, "grid_node_both");
        p = make_particle();
        p.y.fraction = '0;
        p.r.fraction = '0;
        send(p, 1'b0, "grid_node_y");
        p = make_particle();
        p.x.fraction = '0;
        p.r.fraction = '0;
        send(p, 1'b0, "grid_node_x");
        wait_drain("grid_node");

        for (int i = 0; i < 20; i++) begin
            send(make_particle(), 1'b0, "throughput");
        end
        wait_drain("throughput");

        $display("Test completed successfully");
        $finish;
    end

endmodule
